//--- spi_pkg.sv
package spi_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int DATA_WIDTH = 16;
    localparam int DIV_WIDTH  = 16;
    localparam int CNT_WIDTH  = $clog2(DATA_WIDTH) + 1;   // holds 0..DATA_WIDTH

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [DIV_WIDTH-1:0]  div_t;    // half period minus one, in seq cycles
    typedef logic [3:0]            len_t;    // zero encodes a full 16-bit frame
    typedef logic [CNT_WIDTH-1:0]  cnt_t;

    // ------------------------------------------------------------------
    // configuration and pads
    // ------------------------------------------------------------------
    typedef struct packed {
        logic tx_enable;
        logic rx_enable;
        logic master;        // 1 = drive sclk and ss_n
        logic cpol;          // idle level of sclk
        logic cpha;
        logic lsb_first;
        len_t data_length;
        div_t baud_div;
    } spi_cfg_t;

    typedef struct packed {
        logic sclk;
        logic mosi;
        logic miso;
        logic ss_n;
    } spi_pad_in_t;

    typedef struct packed {
        logic sclk;
        logic mosi;
        logic miso;
        logic ss_n;
        logic sclk_oe;
        logic mosi_oe;
        logic miso_oe;
        logic ss_n_oe;
    } spi_pad_out_t;

    // single cycle event pulses
    typedef struct packed {
        logic lead;     // sclk leaves the idle level
        logic trail;    // sclk returns to the idle level
        logic sel;      // ss_n falls
        logic desel;    // ss_n rises
    } spi_edge_t;

    typedef enum logic [2:0] {
        idle,
        select,
        xfer,
        finish,
        hold,
        paused
    } spi_state_e;

    // number of bits in a frame
    function automatic cnt_t frame_bits(input len_t len);
        return (len == '0) ? cnt_t'(DATA_WIDTH) : cnt_t'(len);
    endfunction

endpackage

//--- spi_clkgen.sv
module spi_clkgen (
    input  logic               seq,
    input  logic               rst_n,
    input  logic               run,
    input  logic               cpol,
    input  spi_pkg::div_t      baud_div,
    output logic               sclk,
    output spi_pkg::spi_edge_t clk_edge
);

    spi_pkg::div_t cnt;
    logic          expire;

    assign expire = run && (cnt == '0);

    // first toggle comes one full half period after run rises
    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            sclk <= 1'b0;
        end else if (!run) begin
            cnt  <= baud_div;
            sclk <= cpol;              // park at idle level
        end else if (expire) begin
            cnt  <= baud_div;
            sclk <= ~sclk;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    // pulse lines up with the cycle before sclk changes
    always_comb begin
        clk_edge       = '0;
        clk_edge.lead  = expire && (sclk == cpol);
        clk_edge.trail = expire && (sclk != cpol);
    end

endmodule

//--- spi_pin_sync.sv
module spi_pin_sync (
    input  logic                 seq,
    input  logic                 rst_n,
    input  spi_pkg::spi_pad_in_t pad_in,
    input  logic                 cpol,
    output spi_pkg::spi_edge_t   pin_edge,
    output logic                 mosi_sync
);

    // [0],[1] synchronizer, [2] delay flop for edge detection
    logic [2:0] sclk_q;
    logic [2:0] mosi_q;
    logic [2:0] ss_q;

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            sclk_q <= '0;
            mosi_q <= '0;
            ss_q   <= '1;                  // deselected
        end else begin
            sclk_q <= {sclk_q[1:0], pad_in.sclk};
            mosi_q <= {mosi_q[1:0], pad_in.mosi};
            ss_q   <= {ss_q[1:0], pad_in.ss_n};
        end
    end

    always_comb begin
        pin_edge.lead  = (sclk_q[1] != cpol) && (sclk_q[2] == cpol);
        pin_edge.trail = (sclk_q[1] == cpol) && (sclk_q[2] != cpol);
        pin_edge.sel   = !ss_q[1] && ss_q[2];
        pin_edge.desel = ss_q[1] && !ss_q[2];
    end

    assign mosi_sync = mosi_q[2];      // same delay as the edge pulses

endmodule

//--- spi_shift.sv
module spi_shift (
    input  logic           seq,
    input  logic           rst_n,
    input  logic           load,
    input  spi_pkg::data_t tx_word,
    input  logic           shift_out,
    input  logic           sample_in,
    input  logic           rx_bit,
    input  logic           lsb_first,
    input  spi_pkg::len_t  data_length,
    output logic           tx_bit,
    output spi_pkg::data_t rx_word
);

    localparam int W = spi_pkg::DATA_WIDTH;

    spi_pkg::cnt_t  nbits;
    spi_pkg::data_t len_mask;
    spi_pkg::data_t tx_sr;
    spi_pkg::data_t rx_next;

    assign nbits    = spi_pkg::frame_bits(data_length);
    assign len_mask = spi_pkg::data_t'('1) >> (W - nbits);

    // ------------------------------------------------------------------
    // transmit
    // ------------------------------------------------------------------
    // msb first keeps the first bit at the top, lsb first at the bottom
    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            tx_sr <= '0;
        end else if (load) begin
            if (lsb_first) begin
                tx_sr <= tx_word;
            end else begin
                tx_sr <= tx_word << (W - nbits);
            end
        end else if (shift_out) begin
            if (lsb_first) begin
                tx_sr <= tx_sr >> 1;
            end else begin
                tx_sr <= tx_sr << 1;
            end
        end
    end

    assign tx_bit = lsb_first ? tx_sr[0] : tx_sr[W-1];

    // ------------------------------------------------------------------
    // receive
    // ------------------------------------------------------------------
    // old content falls off after nbits samples
    always_comb begin
        if (lsb_first) begin
            rx_next = ((rx_word >> 1) & (len_mask >> 1))
                    | (spi_pkg::data_t'(rx_bit) << (nbits - 1'b1));
        end else begin
            rx_next = ((rx_word << 1) | spi_pkg::data_t'(rx_bit)) & len_mask;
        end
    end

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            rx_word <= '0;
        end else if (sample_in) begin
            rx_word <= rx_next;
        end
    end

endmodule

//--- spi_ctrl.sv
module spi_ctrl (
    input  logic               seq,
    input  logic               rst_n,
    input  spi_pkg::spi_cfg_t  cfg,
    input  logic               tx_valid,
    input  logic               rx_ready,
    input  logic               pause_req,
    input  spi_pkg::spi_edge_t clk_edge,
    input  spi_pkg::spi_edge_t pin_edge,
    output logic               tx_ready,
    output logic               rx_valid,
    output logic               pause_ack,
    output logic               clk_run,
    output logic               load,
    output logic               shift_out,
    output logic               sample_in,
    output logic               ss_n,
    output logic               active
);

    spi_pkg::spi_state_e state;
    spi_pkg::cnt_t       bit_cnt;      // sample edges seen this frame
    spi_pkg::cnt_t       nbits;
    spi_pkg::div_t       half_cnt;
    logic                drop;         // slave frame met a full rx word
    logic                idle_free;
    logic                start_m;
    logic                start_s;
    logic                in_frame;
    logic                lead;
    logic                trail;
    logic                sample_edge;
    logic                shift_edge;
    logic                last_sample;
    logic                done;

    assign nbits    = spi_pkg::frame_bits(cfg.data_length);
    assign in_frame = (state == spi_pkg::select) || (state == spi_pkg::xfer);

    // ------------------------------------------------------------------
    // frame start and streams
    // ------------------------------------------------------------------
    assign idle_free = (state == spi_pkg::idle) && !pause_req;
    assign start_m   = idle_free && cfg.master && cfg.tx_enable && !rx_valid && tx_valid;
    assign start_s   = idle_free && active && !cfg.master && pin_edge.sel;

    // slave takes a word only at the select edge
    assign tx_ready  = idle_free && cfg.tx_enable && (cfg.master ? !rx_valid : pin_edge.sel);
    assign load      = start_m || start_s;
    assign pause_ack = (state == spi_pkg::paused);
    assign clk_run   = cfg.master && in_frame;

    // ------------------------------------------------------------------
    // edge mapping
    // ------------------------------------------------------------------
    assign lead  = cfg.master ? clk_edge.lead  : pin_edge.lead;
    assign trail = cfg.master ? clk_edge.trail : pin_edge.trail;

    assign sample_edge = in_frame && (cfg.cpha ? trail : lead);
    assign shift_edge  = in_frame && (cfg.cpha ? lead : trail);
    assign sample_in   = sample_edge && !drop;
    // cpha 1 presents the first bit at load, so the first lead is skipped
    assign shift_out   = shift_edge && !(cfg.cpha && (bit_cnt == '0));
    assign last_sample = sample_edge && (bit_cnt == nbits - 1'b1);

    always_comb begin
        if (cfg.master) begin
            done = in_frame && trail && (cfg.cpha ? last_sample : (bit_cnt == nbits));
        end else begin
            done = in_frame && (pin_edge.desel || last_sample);
        end
    end

    // ------------------------------------------------------------------
    // frame FSM
    // ------------------------------------------------------------------
    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            state    <= spi_pkg::idle;
            ss_n     <= 1'b1;
            rx_valid <= 1'b0;
            bit_cnt  <= '0;
            half_cnt <= '0;
            drop     <= 1'b0;
            active   <= 1'b0;
        end else begin
            if (rx_valid && rx_ready) begin
                rx_valid <= 1'b0;
            end
            if (sample_edge) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (state == spi_pkg::paused) begin
                active <= 1'b1;                    // config taken at least once
            end

            case (state)
                spi_pkg::idle: begin
                    if (pause_req) begin
                        state <= spi_pkg::paused;
                    end else if (start_m) begin
                        state   <= spi_pkg::select;
                        ss_n    <= 1'b0;
                        bit_cnt <= '0;
                        drop    <= 1'b0;
                    end else if (start_s) begin
                        state   <= spi_pkg::xfer;
                        ss_n    <= 1'b0;
                        bit_cnt <= '0;
                        drop    <= rx_valid;
                    end
                end

                spi_pkg::select, spi_pkg::xfer: begin
                    if (done) begin
                        if (cfg.master) begin
                            state    <= spi_pkg::finish;
                            half_cnt <= cfg.baud_div;
                        end else begin
                            state <= spi_pkg::idle;
                            ss_n  <= 1'b1;
                            if (!drop) begin
                                rx_valid <= cfg.rx_enable;
                            end
                        end
                    end else if (lead) begin
                        state <= spi_pkg::xfer;        // setup half is over
                    end
                end

                // last clock half, select still low
                spi_pkg::finish: begin
                    if (half_cnt == '0) begin
                        state    <= spi_pkg::hold;
                        ss_n     <= 1'b1;
                        half_cnt <= cfg.baud_div;
                    end else begin
                        half_cnt <= half_cnt - 1'b1;
                    end
                end

                spi_pkg::hold: begin
                    if (half_cnt == '0) begin
                        state    <= spi_pkg::idle;
                        rx_valid <= cfg.rx_enable;
                    end else begin
                        half_cnt <= half_cnt - 1'b1;
                    end
                end

                spi_pkg::paused: begin
                    if (!pause_req) begin
                        state <= spi_pkg::idle;
                    end
                end

                default: state <= spi_pkg::idle;
            endcase
        end
    end

endmodule

//--- spi_phy.sv
module spi_phy (
    input  logic                  seq,
    input  logic                  rst_n,
    input  spi_pkg::spi_cfg_t     cfg,
    input  spi_pkg::data_t        tx_data,
    input  logic                  tx_valid,
    output logic                  tx_ready,
    output spi_pkg::data_t        rx_data,
    output logic                  rx_valid,
    input  logic                  rx_ready,
    input  logic                  pause_req,
    output logic                  pause_ack,
    input  spi_pkg::spi_pad_in_t  pad_in,
    output spi_pkg::spi_pad_out_t pad_out
);

    spi_pkg::spi_cfg_t  cfg_q;
    spi_pkg::spi_edge_t clk_edge;
    spi_pkg::spi_edge_t pin_edge;
    spi_pkg::data_t     tx_word;
    spi_pkg::data_t     rx_word;
    logic               clk_run;
    logic               load;
    logic               shift_out;
    logic               sample_in;
    logic               ss_n;
    logic               active;
    logic               sclk;
    logic               mosi_sync;
    logic               tx_bit;
    logic               rx_bit;

    // config only follows the input while paused
    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q <= '0;
        end else if (pause_ack) begin
            cfg_q <= cfg;
        end
    end

    assign tx_word = (tx_valid && tx_ready) ? tx_data : '0;   // zeros when nothing queued
    assign rx_bit  = cfg_q.master ? pad_in.miso : mosi_sync;
    assign rx_data = rx_word;

    spi_ctrl u_ctrl (
        .seq       (seq),
        .rst_n     (rst_n),
        .cfg       (cfg_q),
        .tx_valid  (tx_valid),
        .rx_ready  (rx_ready),
        .pause_req (pause_req),
        .clk_edge  (clk_edge),
        .pin_edge  (pin_edge),
        .tx_ready  (tx_ready),
        .rx_valid  (rx_valid),
        .pause_ack (pause_ack),
        .clk_run   (clk_run),
        .load      (load),
        .shift_out (shift_out),
        .sample_in (sample_in),
        .ss_n      (ss_n),
        .active    (active)
    );

    spi_clkgen u_clkgen (
        .seq      (seq),
        .rst_n    (rst_n),
        .run      (clk_run),
        .cpol     (cfg_q.cpol),
        .baud_div (cfg_q.baud_div),
        .sclk     (sclk),
        .clk_edge (clk_edge)
    );

    spi_pin_sync u_pin_sync (
        .seq       (seq),
        .rst_n     (rst_n),
        .pad_in    (pad_in),
        .cpol      (cfg_q.cpol),
        .pin_edge  (pin_edge),
        .mosi_sync (mosi_sync)
    );

    spi_shift u_shift (
        .seq         (seq),
        .rst_n       (rst_n),
        .load        (load),
        .tx_word     (tx_word),
        .shift_out   (shift_out),
        .sample_in   (sample_in),
        .rx_bit      (rx_bit),
        .lsb_first   (cfg_q.lsb_first),
        .data_length (cfg_q.data_length),
        .tx_bit      (tx_bit),
        .rx_word     (rx_word)
    );

    // ------------------------------------------------------------------
    // pads
    // ------------------------------------------------------------------
    always_comb begin
        pad_out.sclk    = sclk;
        pad_out.mosi    = tx_bit;
        pad_out.miso    = tx_bit;
        pad_out.ss_n    = ss_n;
        pad_out.sclk_oe = active && cfg_q.master;
        pad_out.mosi_oe = active && cfg_q.master;
        pad_out.ss_n_oe = active && cfg_q.master;
        pad_out.miso_oe = active && !cfg_q.master && !ss_n;   // slave drives only when selected
    end

endmodule

//--- tb_spi_phy.sv
module tb_spi_phy;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 2000;   // cycles per wait
    localparam int HALF       = 16;     // partner clock half in slave tests

    logic                  seq = 1'b0;
    logic                  rst_n;
    spi_pkg::spi_cfg_t     cfg;
    spi_pkg::data_t        tx_data;
    logic                  tx_valid;
    logic                  tx_ready;
    spi_pkg::data_t        rx_data;
    logic                  rx_valid;
    logic                  rx_ready;
    logic                  pause_req;
    logic                  pause_ack;
    spi_pkg::spi_pad_in_t  pad_in;
    spi_pkg::spi_pad_out_t pad_out;

    int          errors;
    int          checks;
    logic [31:0] lcg_state;

    spi_phy DUT (
        .seq       (seq),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .pad_in    (pad_in),
        .pad_out   (pad_out)
    );

    always #2 seq = ~seq;

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    function automatic spi_pkg::data_t next_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic int frame_len(input spi_pkg::len_t len);
        return (len == 4'd0) ? 16 : int'(len);   // zero stands for 16 bits
    endfunction

    function automatic spi_pkg::data_t low_mask(input int n);
        return spi_pkg::data_t'((32'd1 << n) - 32'd1);
    endfunction

    // bit number i on the wire, for a word of n bits
    function automatic logic wire_bit(input spi_pkg::data_t word, input int i, input int n,
                                      input logic lsb);
        if (i >= n) begin
            return 1'b0;
        end
        return lsb ? word[i] : word[n-1-i];
    endfunction

    function automatic spi_pkg::data_t put_bit(input spi_pkg::data_t acc, input int i,
                                               input int n, input logic lsb, input logic b);
        spi_pkg::data_t r;
        r = acc;
        if (i < n) begin
            if (lsb) begin
                r[i] = b;
            end else begin
                r[n-1-i] = b;
            end
        end
        return r;
    endfunction

    task automatic tick();
        @(posedge seq);
        #1;
    endtask

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Error at %0d ns: no %s within %0d cycles", $time, what, WAIT_LIMIT);
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %-12s : %s", name, (errors == errs_before) ? "ok" : "errors seen");
    endtask

    task automatic wait_pause(input logic level);
        int n;
        n = 0;
        while (pause_ack !== level && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (pause_ack !== level) begin
            report_timeout(level ? "pause_ack rise" : "pause_ack fall");
        end
    endtask

    task automatic wait_rx_valid();
        int n;
        n = 0;
        while (!rx_valid && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (!rx_valid) begin
            report_timeout("rx_valid");
        end
    endtask

    task automatic configure(input logic master, input logic cpol, input logic cpha,
                             input logic lsb, input spi_pkg::len_t len);
        cfg.tx_enable   = 1'b1;
        cfg.rx_enable   = 1'b1;
        cfg.master      = master;
        cfg.cpol        = cpol;
        cfg.cpha        = cpha;
        cfg.lsb_first   = lsb;
        cfg.data_length = len;
        cfg.baud_div    = 16'd3;      // 4-cycle halves
        pause_req = 1'b1;
        wait_pause(1'b1);
        tick();                        // config register loads here
        pause_req = 1'b0;
        wait_pause(1'b0);
    endtask

    // ------------------------------------------------------------------
    // stream side
    // ------------------------------------------------------------------
    task automatic send_word(input spi_pkg::data_t word);
        int n;
        tx_data  = word;
        tx_valid = 1'b1;
        n = 0;
        while (!tx_ready && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (tx_ready) begin
            tick();                    // handshake edge
        end else begin
            report_timeout("tx_ready");
        end
        tx_valid = 1'b0;
    endtask

    task automatic take_rx(input spi_pkg::data_t exp);
        wait_rx_valid();
        if (rx_valid) begin
            check("rx_data", rx_data, exp);
            rx_ready = 1'b1;
            tick();
            rx_ready = 1'b0;
        end
    endtask

    // ------------------------------------------------------------------
    // emulated partners
    // ------------------------------------------------------------------
    // slave side of a master frame, runs until ss_n rises again
    task automatic emulate_slave(input spi_pkg::data_t word, output spi_pkg::data_t seen);
        int   n;
        int   out_i;
        int   in_i;
        int   cnt;
        logic prev_ss;
        logic prev_sclk;
        logic lead;
        logic trail;
        logic ended;
        n         = frame_len(cfg.data_length);
        seen      = '0;
        out_i     = 0;
        in_i      = 0;
        cnt       = 0;
        prev_ss   = 1'b1;
        prev_sclk = cfg.cpol;
        ended     = 1'b0;
        while (!ended && cnt < WAIT_LIMIT) begin
            lead  = (pad_out.sclk != prev_sclk) && (pad_out.sclk != cfg.cpol);
            trail = (pad_out.sclk != prev_sclk) && (pad_out.sclk == cfg.cpol);
            if (prev_ss && !pad_out.ss_n && !cfg.cpha) begin
                pad_in.miso = wire_bit(word, 0, n, cfg.lsb_first);   // first bit at select
                out_i = 1;
            end
            if (cfg.cpha ? trail : lead) begin
                seen = put_bit(seen, in_i, n, cfg.lsb_first, pad_out.mosi);
                in_i++;
            end
            if (cfg.cpha ? lead : trail) begin
                pad_in.miso = wire_bit(word, out_i, n, cfg.lsb_first);
                out_i++;
            end
            if (!pad_out.ss_n) begin
                check("pause_ack", 16'(pause_ack), 16'd0);   // never during a frame
            end
            ended     = !prev_ss && pad_out.ss_n;
            prev_ss   = pad_out.ss_n;
            prev_sclk = pad_out.sclk;
            if (!ended) begin
                tick();
                cnt++;
            end
        end
        if (!ended) begin
            report_timeout("end of frame on ss_n");
        end
        check("sample edges", 16'(in_i), 16'(n));
    endtask

    // master side for slave tests, sclk halves of HALF cycles
    task automatic drive_master(input spi_pkg::data_t word, output spi_pkg::data_t seen);
        int n;
        n    = frame_len(cfg.data_length);
        seen = '0;
        pad_in.ss_n = 1'b0;
        if (!cfg.cpha) begin
            pad_in.mosi = wire_bit(word, 0, n, cfg.lsb_first);
        end
        for (int i = 0; i < n; i++) begin
            repeat (HALF) tick();
            pad_in.sclk = ~cfg.cpol;                        // lead
            // only miso is driven while selected
            check("pad_out enables", 16'({pad_out.sclk_oe, pad_out.mosi_oe,
                                          pad_out.miso_oe, pad_out.ss_n_oe}), 16'b0010);
            if (cfg.cpha) begin
                pad_in.mosi = wire_bit(word, i, n, cfg.lsb_first);
            end else begin
                seen = put_bit(seen, i, n, cfg.lsb_first, pad_out.miso);
            end
            repeat (HALF) tick();
            pad_in.sclk = cfg.cpol;                         // trail
            if (cfg.cpha) begin
                seen = put_bit(seen, i, n, cfg.lsb_first, pad_out.miso);
            end else begin
                pad_in.mosi = wire_bit(word, i + 1, n, cfg.lsb_first);
            end
        end
        repeat (HALF) tick();
        pad_in.ss_n = 1'b1;
        repeat (HALF) tick();
        check("pad_out enables", 16'({pad_out.sclk_oe, pad_out.mosi_oe,
                                      pad_out.miso_oe, pad_out.ss_n_oe}), 16'd0);
    endtask

    task automatic master_frame(input spi_pkg::data_t word);
        spi_pkg::data_t reply;
        spi_pkg::data_t seen;
        spi_pkg::data_t mask;
        reply = next_word();
        mask  = low_mask(frame_len(cfg.data_length));
        send_word(word);
        emulate_slave(reply, seen);
        check("mosi word", seen, word & mask);
        take_rx(reply & mask);
    endtask

    task automatic slave_frame(input logic queued);
        spi_pkg::data_t word;
        spi_pkg::data_t sent;
        spi_pkg::data_t seen;
        spi_pkg::data_t mask;
        word = next_word();
        sent = next_word();
        mask = low_mask(frame_len(cfg.data_length));
        fork
            if (queued) send_word(word);
            drive_master(sent, seen);
        join
        check("miso word", seen, queued ? (word & mask) : 16'd0);
        take_rx(sent & mask);
    endtask

    // ------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------
    task automatic reset_values();
        int e;
        e = errors;
        check("tx_ready", 16'(tx_ready), 16'd0);
        check("rx_valid", 16'(rx_valid), 16'd0);
        check("pause_ack", 16'(pause_ack), 16'd0);
        check("pad_out.ss_n", 16'(pad_out.ss_n), 16'd1);
        check("pad_out.sclk", 16'(pad_out.sclk), 16'd0);
        check("pad_out enables", 16'({pad_out.sclk_oe, pad_out.mosi_oe,
                                      pad_out.miso_oe, pad_out.ss_n_oe}), 16'd0);
        configure(1'b1, 1'b1, 1'b0, 1'b0, 4'd8);
        check("pad_out.sclk", 16'(pad_out.sclk), 16'd1);
        check("pad_out enables", 16'({pad_out.sclk_oe, pad_out.mosi_oe,
                                      pad_out.miso_oe, pad_out.ss_n_oe}), 16'b1101);
        report_test("reset", e);
    endtask

    task automatic master_modes();
        int e;
        e = errors;
        for (int m = 0; m < 4; m++) begin
            configure(1'b1, m[1], m[0], 1'b0, 4'd8);
            master_frame(next_word());
        end
        report_test("master modes", e);
    endtask

    task automatic order_and_length();
        int            e;
        spi_pkg::len_t lens [4];
        e    = errors;
        lens = '{4'd4, 4'd8, 4'd13, 4'd0};
        for (int l = 0; l < 2; l++) begin
            for (int k = 0; k < 4; k++) begin
                configure(1'b1, 1'b0, l[0], l[0], lens[k]);
                master_frame(next_word());
            end
        end
        report_test("order/length", e);
    endtask

    task automatic slave_modes();
        int e;
        e = errors;
        for (int m = 0; m < 4; m++) begin
            pad_in.sclk = m[1];        // partner clock idles at cpol
            configure(1'b0, m[1], m[0], m[0] ^ m[1], 4'd10);
            slave_frame(1'b1);
        end
        slave_frame(1'b0);             // nothing queued, miso stays zero
        report_test("slave modes", e);
    endtask

    task automatic pause_blocks_frames();
        int             e;
        spi_pkg::data_t word;
        spi_pkg::data_t reply;
        spi_pkg::data_t seen;
        e = errors;
        configure(1'b1, 1'b0, 1'b0, 1'b0, 4'd8);
        word  = next_word();
        reply = next_word();
        send_word(word);
        pause_req = 1'b1;              // request lands mid frame
        emulate_slave(reply, seen);
        check("pause_ack", 16'(pause_ack), 16'd0);
        check("mosi word", seen, word & 16'h00ff);
        wait_pause(1'b1);
        take_rx(reply & 16'h00ff);
        tx_data  = next_word();
        tx_valid = 1'b1;
        repeat (20) begin
            tick();
            check("pad_out.ss_n", 16'(pad_out.ss_n), 16'd1);
            check("tx_ready", 16'(tx_ready), 16'd0);
        end
        tx_valid  = 1'b0;
        pause_req = 1'b0;
        wait_pause(1'b0);
        master_frame(next_word());
        report_test("pause", e);
    endtask

    task automatic rx_backpressure();
        int             e;
        spi_pkg::data_t word;
        spi_pkg::data_t reply;
        spi_pkg::data_t seen;
        e = errors;
        configure(1'b1, 1'b1, 1'b1, 1'b0, 4'd8);
        word  = next_word();
        reply = next_word();
        send_word(word);
        emulate_slave(reply, seen);
        check("mosi word", seen, word & 16'h00ff);
        wait_rx_valid();
        tx_data  = next_word();
        tx_valid = 1'b1;
        repeat (30) begin
            tick();
            check("rx_valid", 16'(rx_valid), 16'd1);
            check("rx_data", rx_data, reply & 16'h00ff);
            check("pad_out.ss_n", 16'(pad_out.ss_n), 16'd1);
            check("tx_ready", 16'(tx_ready), 16'd0);
        end
        tx_valid = 1'b0;
        take_rx(reply & 16'h00ff);
        master_frame(next_word());
        report_test("backpressure", e);
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        rst_n     = 1'b0;
        cfg       = '0;
        tx_data   = '0;
        tx_valid  = 1'b0;
        rx_ready  = 1'b0;
        pause_req = 1'b0;
        pad_in    = '{sclk: 1'b0, mosi: 1'b0, miso: 1'b0, ss_n: 1'b1};
        errors    = 0;
        checks    = 0;
        lcg_state = 32'h5970b330;
        repeat (5) @(posedge seq);
        #1;
        rst_n = 1'b1;
        tick();

        reset_values();
        master_modes();
        order_and_length();
        slave_modes();
        pause_blocks_frames();
        rx_backpressure();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- list.f
spi_pkg.sv
spi_clkgen.sv
spi_pin_sync.sv
spi_shift.sv
spi_ctrl.sv
spi_phy.sv
tb_spi_phy.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = tb_spi_phy
FILELIST  = list.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
